// File: source/mipsPkg.sv
// encodings follow MIPS32 except HALT (opcode 0x3f); memories are word addressed and aligned only
package mipsPkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcodeT;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		SLT = 3'd4
	} aluOpT;

	// paddr[31:30]
	typedef enum logic [1:0] {
		CTRL = 2'b00,
		IMEM = 2'b01,
		DMEM = 2'b10,
		BAD  = 2'b11
	} apbRegionT;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		logic        valid;
		opcodeT      opcode;
		aluOpT       aluOp;
		logic [4:0]  dest;
		logic        wbEn;
		logic        memRead;
		logic        memWrite;
		logic [1:0]  brType;    // bit 0 beq, bit 1 bne
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] pcPlus4;
	} idExT;

	typedef struct packed {
		logic        valid;
		opcodeT      opcode;
		logic        wbEn;
		logic        memRead;
		logic        memWrite;
		logic [4:0]  dest;
		logic [31:0] aluResult;
		logic [31:0] storeData;
	} exMemT;

	typedef struct packed {
		logic        valid;
		opcodeT      opcode;
		logic        wbEn;
		logic [4:0]  dest;
		logic [31:0] wbData;
	} memWbT;

	// writeback port into the register file
	typedef struct packed {
		logic        en;
		logic [4:0]  addr;
		logic [31:0] data;
	} regWriteT;

endpackage

// File: source/fetchStage.sv
// ImemWords must be a power of two >= 2; PC sits at 0 while run is low and holds once HALT is fetched
`timescale 1ns/1ps

module fetchStage #(
	parameter int ImemWords = 256
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  logic                         branchTaken,
	input  logic [31:0]                  branchTarget,
	input  logic                         imemWrite,
	input  logic [$clog2(ImemWords)-1:0] imemAddr,
	input  logic [31:0]                  imemData,
	output mipsPkg::ifIdT                ifId,
	output logic                         fetchValid
);
	import mipsPkg::*;

	localparam int AddrBits = $clog2(ImemWords);

	logic [31:0] imem [ImemWords];
	logic [31:0] pc;
	logic [31:0] fetchWord;
	logic        haltFetched;
	logic        fetching;

	assign fetchWord = imem[pc[AddrBits+1:2]];
	// the slot fetched during a taken branch is dropped
	assign fetching = run && !haltFetched && !branchTaken;

	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || !run) begin
			pc          <= 32'd0;
			haltFetched <= 1'b0;
		end else if (branchTaken) begin
			// a HALT in the branch shadow never counts
			pc          <= branchTarget;
			haltFetched <= 1'b0;
		end else if (!haltFetched) begin
			pc          <= pc + 32'd4;
			haltFetched <= (fetchWord[31:26] == HALT);
		end
	end

	always_ff @(posedge clk) begin
		ifId.instr   <= fetchWord;
		ifId.pcPlus4 <= pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= fetching;
		end
	end

	// program ran off the end of instruction memory without a HALT
	pcInRange: assert property (@(posedge clk) disable iff (rst)
		fetching |-> (pc >> 2) < ImemWords)
		else $error("fetch PC %h outside instruction memory", pc);

endmodule

// File: source/decodeStage.sv
// no forwarding; the register file writes first, so a result reaches the third younger instruction
`timescale 1ns/1ps

module decodeStage (
	input  logic              clk,
	input  logic              rst,
	input  mipsPkg::ifIdT     ifId,
	input  logic              fetchValid,
	input  logic              flush,
	input  mipsPkg::regWriteT regWrite,
	output mipsPkg::idExT     idEx
);
	import mipsPkg::*;

	// funct field of R-type words
	localparam logic [5:0] FunctAdd = 6'h20;
	localparam logic [5:0] FunctSub = 6'h22;
	localparam logic [5:0] FunctAnd = 6'h24;
	localparam logic [5:0] FunctOr  = 6'h25;
	localparam logic [5:0] FunctSlt = 6'h2a;

	logic [31:0] regs [32];
	opcodeT      opcode;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [5:0]  funct;
	logic        legal;
	idExT        idExNext;

	assign opcode = opcodeT'(ifId.instr[31:26]);
	assign rs     = ifId.instr[25:21];
	assign rt     = ifId.instr[20:16];
	assign rd     = ifId.instr[15:11];
	assign funct  = ifId.instr[5:0];

	function automatic logic [31:0] readReg(input logic [4:0] addr);
		logic [31:0] value;
		if (addr == 5'd0) begin
			value = 32'd0;
		end else if (regWrite.en && regWrite.addr == addr) begin
			// same-cycle write wins
			value = regWrite.data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		legal             = 1'b1;
		idExNext.aluOp    = ADD;
		idExNext.dest     = rt;
		idExNext.wbEn     = 1'b0;
		idExNext.memRead  = 1'b0;
		idExNext.memWrite = 1'b0;
		idExNext.brType   = 2'b00;
		case (opcode)
			RTYPE: begin
				idExNext.wbEn = 1'b1;
				idExNext.dest = rd;
				case (funct)
					FunctAdd: idExNext.aluOp = ADD;
					FunctSub: idExNext.aluOp = SUB;
					FunctAnd: idExNext.aluOp = AND;
					FunctOr:  idExNext.aluOp = OR;
					FunctSlt: idExNext.aluOp = SLT;
					default:  legal = 1'b0;
				endcase
			end
			ADDI: idExNext.wbEn = 1'b1;
			LW: begin
				idExNext.wbEn    = 1'b1;
				idExNext.memRead = 1'b1;
			end
			SW:      idExNext.memWrite = 1'b1;
			BEQ:     idExNext.brType = 2'b01;
			BNE:     idExNext.brType = 2'b10;
			HALT:    legal = 1'b1;
			default: legal = 1'b0;
		endcase
		idExNext.valid   = fetchValid && legal && !flush;
		idExNext.opcode  = opcode;
		idExNext.rsVal   = readReg(rs);
		idExNext.rtVal   = readReg(rt);
		idExNext.imm     = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
		idExNext.pcPlus4 = ifId.pcPlus4;
	end

	// register 0 is never written
	always_ff @(posedge clk) begin
		if (regWrite.en && regWrite.addr != 5'd0) begin
			regs[regWrite.addr] <= regWrite.data;
		end
	end

	always_ff @(posedge clk) begin
		idEx <= idExNext;
		if (rst) begin
			idEx.valid <= 1'b0;
		end
	end

	// unknown opcodes never reach execute
	illegalDropped: assert property (@(posedge clk) disable iff (rst)
		idEx.valid |-> idEx.opcode inside {RTYPE, ADDI, LW, SW, BEQ, BNE, HALT})
		else $error("illegal opcode %h entered execute", idEx.opcode);

endmodule

// File: source/executeStage.sv
// branches resolve here; the caller must flush the two younger slots when branchTaken is high
`timescale 1ns/1ps

module executeStage (
	input  logic           clk,
	input  logic           rst,
	input  mipsPkg::idExT  idEx,
	output mipsPkg::exMemT exMem,
	output logic           branchTaken,
	output logic [31:0]    branchTarget
);
	import mipsPkg::*;

	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic        regsEqual;
	exMemT       exMemNext;

	// immediate for ADDI, LW and SW
	assign aluB = (idEx.opcode == RTYPE) ? idEx.rtVal : idEx.imm;

	always_comb begin
		case (idEx.aluOp)
			ADD:     aluResult = idEx.rsVal + aluB;
			SUB:     aluResult = idEx.rsVal - aluB;
			AND:     aluResult = idEx.rsVal & aluB;
			OR:      aluResult = idEx.rsVal | aluB;
			SLT:     aluResult = {31'd0, $signed(idEx.rsVal) < $signed(aluB)};
			default: aluResult = 32'd0;
		endcase
	end

	assign regsEqual = (idEx.rsVal == idEx.rtVal);

	assign branchTaken = idEx.valid &&
		((idEx.brType[0] && regsEqual) || (idEx.brType[1] && !regsEqual));

	// word offset relative to the slot after the branch
	assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

	always_comb begin
		exMemNext.valid     = idEx.valid;
		exMemNext.opcode    = idEx.opcode;
		exMemNext.wbEn      = idEx.wbEn;
		exMemNext.memRead   = idEx.memRead;
		exMemNext.memWrite  = idEx.memWrite;
		exMemNext.dest      = idEx.dest;
		exMemNext.aluResult = aluResult;
		exMemNext.storeData = idEx.rtVal;
	end

	always_ff @(posedge clk) begin
		exMem <= exMemNext;
		if (rst) begin
			exMem.valid <= 1'b0;
		end
	end

	// a taken branch leaves a bubble behind it in decode
	flushBubble: assert property (@(posedge clk) disable iff (rst)
		branchTaken |=> !idEx.valid)
		else $error("instruction after a taken branch reached execute");

endmodule

// File: source/memoryStage.sv
// DmemWords must be a power of two >= 2; data memory has no reset and the APB read port lags one cycle
`timescale 1ns/1ps

module memoryStage #(
	parameter int DmemWords = 256
) (
	input  logic                         clk,
	input  logic                         rst,
	input  mipsPkg::exMemT               exMem,
	input  logic [$clog2(DmemWords)-1:0] dmemReadAddr,
	output mipsPkg::regWriteT            regWrite,
	output mipsPkg::memWbT               memWb,
	output logic [31:0]                  dmemReadData
);
	import mipsPkg::*;

	localparam int AddrBits = $clog2(DmemWords);

	logic [31:0]         dmem [DmemWords];
	logic [AddrBits-1:0] wordAddr;
	logic                accessing;
	memWbT               memWbNext;

	assign wordAddr  = exMem.aluResult[AddrBits+1:2];
	assign accessing = exMem.valid && (exMem.memRead || exMem.memWrite);

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.memWrite) begin
			dmem[wordAddr] <= exMem.storeData;
		end
	end

	// host port, registered
	always_ff @(posedge clk) begin
		dmemReadData <= dmem[dmemReadAddr];
	end

	always_comb begin
		memWbNext.valid  = exMem.valid;
		memWbNext.opcode = exMem.opcode;
		memWbNext.wbEn   = exMem.wbEn;
		memWbNext.dest   = exMem.dest;
		memWbNext.wbData = exMem.memRead ? dmem[wordAddr] : exMem.aluResult;
	end

	always_ff @(posedge clk) begin
		memWb <= memWbNext;
		if (rst) begin
			memWb.valid <= 1'b0;
		end
	end

	// writeback straight out of the memWb register
	assign regWrite = {memWb.valid && memWb.wbEn, memWb.dest, memWb.wbData};

	// address comes from the program through execute
	accessInRange: assert property (@(posedge clk) disable iff (rst)
		accessing |-> (exMem.aluResult >> 2) < DmemWords && exMem.aluResult[1:0] == 2'b00)
		else $error("data access at %h out of range or unaligned", exMem.aluResult);

endmodule

// File: source/apbControl.sv
// APB slave with no wait states; paddr[31:30] picks the region, paddr[1:0] is ignored
`timescale 1ns/1ps

module apbControl #(
	parameter int ImemWords = 256,
	parameter int DmemWords = 256
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [31:0]                  paddr,
	input  logic [31:0]                  pwdata,
	input  logic                         haltRetired,
	input  logic [31:0]                  dmemReadData,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,
	output logic                         run,
	output logic                         imemWrite,
	output logic [$clog2(ImemWords)-1:0] imemAddr,
	output logic [31:0]                  imemData,
	output logic [$clog2(DmemWords)-1:0] dmemReadAddr
);
	import mipsPkg::*;

	apbRegionT region;
	logic      access;
	logic      accessError;
	logic      halted;

	assign region = apbRegionT'(paddr[31:30]);
	assign access = psel && penable;

	// memories belong to the core while it runs
	always_comb begin
		case (region)
			CTRL:    accessError = 1'b0;
			IMEM:    accessError = run || !pwrite;
			DMEM:    accessError = run || pwrite;
			default: accessError = 1'b1;
		endcase
	end

	assign pready  = access;
	assign pslverr = access && accessError;

	assign imemWrite    = access && pwrite && !accessError && region == IMEM;
	assign imemAddr     = paddr[$clog2(ImemWords)+1:2];
	assign imemData     = pwdata;
	// presented in setup so the data is ready in access
	assign dmemReadAddr = paddr[$clog2(DmemWords)+1:2];

	always_comb begin
		prdata = 32'd0;
		if (access && !pwrite && !accessError) begin
			case (region)
				CTRL:    prdata = {30'd0, halted, run};
				DMEM:    prdata = dmemReadData;
				default: prdata = 32'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run    <= 1'b0;
			halted <= 1'b0;
		end else if (haltRetired) begin
			run    <= 1'b0;
			halted <= 1'b1;
		end else if (access && pwrite && region == CTRL && pwdata[0]) begin
			run    <= 1'b1;
			halted <= 1'b0;
		end
	end

	penableNeedsSel: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel)
		else $error("penable high without psel");

	// a setup cycle is always followed by its access cycle
	setupThenAccess: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable)
		else $error("APB setup not followed by access");

endmodule

// File: source/mipsCore.sv
// no hazard interlock; a consumer must be at least three instructions after its producer
`timescale 1ns/1ps

module mipsCore #(
	parameter int ImemWords = 256,
	parameter int DmemWords = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [31:0]      paddr,
	input  logic [31:0]      pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	output mipsPkg::opcodeT  retiredOpcode,
	output logic             retiredValid
);
	import mipsPkg::*;

	ifIdT                         ifId;
	idExT                         idEx;
	exMemT                        exMem;
	memWbT                        memWb;
	regWriteT                     regWrite;
	logic                         fetchValid;
	logic                         branchTaken;
	logic [31:0]                  branchTarget;
	logic                         run;
	logic                         haltRetired;
	logic                         imemWrite;
	logic [$clog2(ImemWords)-1:0] imemAddr;
	logic [31:0]                  imemData;
	logic [$clog2(DmemWords)-1:0] dmemReadAddr;
	logic [31:0]                  dmemReadData;

	assign retiredOpcode = memWb.opcode;
	assign retiredValid  = memWb.valid;
	assign haltRetired   = memWb.valid && memWb.opcode == HALT;

	fetchStage #(.ImemWords(ImemWords)) fetchInst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifId(ifId),
		.fetchValid(fetchValid)
	);

	decodeStage decodeInst (
		.clk(clk),
		.rst(rst),
		.ifId(ifId),
		.fetchValid(fetchValid),
		.flush(branchTaken),
		.regWrite(regWrite),
		.idEx(idEx)
	);

	executeStage executeInst (
		.clk(clk),
		.rst(rst),
		.idEx(idEx),
		.exMem(exMem),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	memoryStage #(.DmemWords(DmemWords)) memoryInst (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.dmemReadAddr(dmemReadAddr),
		.regWrite(regWrite),
		.memWb(memWb),
		.dmemReadData(dmemReadData)
	);

	apbControl #(.ImemWords(ImemWords), .DmemWords(DmemWords)) apbInst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.haltRetired(haltRetired),
		.dmemReadData(dmemReadData),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dmemReadAddr(dmemReadAddr)
	);

endmodule

// File: test/mipsCore_tb.sv
// run from the project root; reads test/mipsCore_testdata.txt and assumes the default memory depths
`timescale 1ns/1ps

module mipsCore_tb;
	import mipsPkg::*;

	localparam int ImemWords     = 256;
	localparam int DmemWords     = 256;
	localparam int CyclesPerLine = 200;
	localparam int ResetCycles   = 16;

	// one line of the data file
	typedef struct packed {
		logic [7:0]   kind;
		logic [31:0]  addr;
		logic [31:0]  data;
		logic         err;
		logic [127:0] name;
	} dataOpT;

	logic         clk;
	logic         rst;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [31:0]  paddr;
	logic [31:0]  pwdata;
	logic [31:0]  prdata;
	logic         pready;
	logic         pslverr;
	opcodeT       retiredOpcode;
	logic         retiredValid;

	dataOpT       ops[$];
	logic         opsLoaded = 1'b0;
	int           haltCount = 0;
	int           haltBase;
	int           testCount;
	int           testsFailed;
	int           checkCount;
	int           errorCount;
	int           testChecks;
	int           testErrors;
	logic         testOpen;
	logic [127:0] testName;

	mipsCore #(.ImemWords(ImemWords), .DmemWords(DmemWords)) mipsCore_inst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.retiredOpcode(retiredOpcode),
		.retiredValid(retiredValid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// sampled mid-cycle, away from the register updates
	always @(negedge clk) begin
		if (!rst && retiredValid && retiredOpcode == HALT) begin
			haltCount <= haltCount + 1;
		end
	end

	initial begin : watchdog
		wait (opsLoaded);
		repeat (CyclesPerLine * ops.size()) @(posedge clk);
		$display("timeout: the tests did not finish within %0d clock cycles",
			CyclesPerLine * ops.size());
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic recordError();
		errorCount++;
		testErrors++;
	endtask

	task automatic countCheck();
		checkCount++;
		testChecks++;
	endtask

	task automatic loadOps(output logic ok);
		int           fd;
		int           ch;
		logic [7:0]   kind;
		logic [31:0]  addr;
		logic [31:0]  data;
		logic         err;
		logic [127:0] name;
		dataOpT       op;
		ok = 1'b1;
		fd = $fopen("test/mipsCore_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/mipsCore_testdata.txt");
			ok = 1'b0;
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				op      = '0;
				op.kind = kind;
				case (kind)
					"#": begin
						ch = 0;
						while (ch != 10 && ch != -1) begin
							ch = $fgetc(fd);
						end
					end
					"T": begin
						if ($fscanf(fd, " %s", name) != 1) ok = 1'b0;
						op.name = name;
					end
					"W", "R": begin
						if ($fscanf(fd, " %h %h %b", addr, data, err) != 3) ok = 1'b0;
						op.addr = addr;
						op.data = data;
						op.err  = err;
					end
					"H": begin
						if ($fscanf(fd, " %d", data) != 1) ok = 1'b0;
						op.data = data;
					end
					"P": op.data = 32'd0;
					default: begin
						$display("unknown line kind '%c' in the test data file", kind);
						ok = 1'b0;
					end
				endcase
				if (kind != "#") begin
					ops.push_back(op);
				end
			end
			$fclose(fd);
			if (!ok) begin
				$display("the test data file has a malformed line");
			end
		end
	endtask

	// one APB transfer after a random idle gap
	task automatic apbTransfer(input logic isWrite, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int gap;
		int waits;
		gap = $urandom % 4;
		repeat (gap) @(posedge clk);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= isWrite;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		waits = 0;
		while (!pready && waits < 4) begin
			@(negedge clk);
			waits++;
		end
		if (!pready) begin
			$display("APB transfer to %h was never completed by pready", addr);
			recordError();
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic waitHalted();
		logic [31:0] status;
		logic        err;
		status = 32'd0;
		while (status[1] !== 1'b1) begin
			apbTransfer(1'b0, 32'h0000_0000, 32'd0, status, err);
		end
	endtask

	task automatic closeTest();
		if (testOpen) begin
			testCount++;
			if (testErrors != 0) begin
				testsFailed++;
			end
			$display("test %0s: %0d checks, %0d errors", testName, testChecks, testErrors);
		end
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic runOp(input dataOpT op);
		logic [31:0] rdata;
		logic        err;
		case (op.kind)
			"T": begin
				closeTest();
				testName = op.name;
				testOpen = 1'b1;
				haltBase = haltCount;
			end
			"W", "R": begin
				apbTransfer(op.kind == "W", op.addr, op.data, rdata, err);
				countCheck();
				if (err !== op.err) begin
					$display("Mismatch at %0t: pslverr for %h was %b, expected %b",
						$time, op.addr, err, op.err);
					recordError();
				end
				if (op.kind == "R") begin
					countCheck();
					if (rdata !== op.data) begin
						$display("Mismatch at %0t: read of %h returned %h, expected %h",
							$time, op.addr, rdata, op.data);
						recordError();
					end
				end
			end
			"P": waitHalted();
			"H": begin
				countCheck();
				if (haltCount - haltBase != int'(op.data)) begin
					$display("Mismatch at %0t: %0d HALT retirements, expected %0d",
						$time, haltCount - haltBase, op.data);
					recordError();
				end
			end
			default: begin
			end
		endcase
	endtask

	initial begin : mainFlow
		logic        loadOk;
		logic [31:0] seedValue;
		seedValue   = $urandom(32'h08c9ef54);
		rst         <= 1'b1;
		psel        <= 1'b0;
		penable     <= 1'b0;
		pwrite      <= 1'b0;
		paddr       <= 32'd0;
		pwdata      <= 32'd0;
		testCount   = 0;
		testsFailed = 0;
		checkCount  = 0;
		errorCount  = 0;
		testChecks  = 0;
		testErrors  = 0;
		testOpen    = 1'b0;
		haltBase    = 0;
		testName    = '0;
		loadOps(loadOk);
		if (loadOk) begin
			opsLoaded = 1'b1;
			repeat (ResetCycles) @(posedge clk);
			rst <= 1'b0;
			foreach (ops[i]) begin
				runOp(ops[i]);
			end
			closeTest();
		end else begin
			recordError();
		end
		$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			testCount, testCount - testsFailed, testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
source/mipsPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/apbControl.sv
source/mipsCore.sv
test/mipsCore_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = mipsCore_tb
FILELIST = flist.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = TEST RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/mipsCore_testdata.txt
# T name | W addr data err | R addr expected_prdata expected_pslverr | P polls until halted | H n
# addr and data in hex, err is the expected pslverr, H n checks the HALT retirements of the test
T rtype
W 40000000 2001000c 0
W 40000004 20020005 0
W 40000008 00000020 0
W 4000000c 00000020 0
W 40000010 00221820 0
W 40000014 00222022 0
W 40000018 00222824 0
W 4000001c 00223025 0
W 40000020 0041382a 0
W 40000024 ac030000 0
W 40000028 ac040004 0
W 4000002c ac050008 0
W 40000030 ac06000c 0
W 40000034 ac070010 0
W 40000038 fc000000 0
W 00000000 00000001 0
P
R 80000000 00000011 0
R 80000004 00000007 0
R 80000008 00000004 0
R 8000000c 0000000d 0
R 80000010 00000001 0
H 1
T loadstore
W 40000000 20010064 0
W 40000004 2002fff9 0
W 40000008 00000020 0
W 4000000c ac010020 0
W 40000010 ac020024 0
W 40000014 8c030020 0
W 40000018 8c040024 0
W 4000001c 00000020 0
W 40000020 00000020 0
W 40000024 00642820 0
W 40000028 20660001 0
W 4000002c 00000020 0
W 40000030 ac050028 0
W 40000034 ac060020 0
W 40000038 fc000000 0
W 00000000 00000001 0
P
R 80000020 00000065 0
R 80000024 fffffff9 0
R 80000028 0000005d 0
H 1
T branch
W 40000000 20010003 0
W 40000004 20020003 0
W 40000008 20030009 0
W 4000000c ac000030 0
W 40000010 ac000034 0
W 40000014 10220002 0
W 40000018 ac030030 0
W 4000001c ac030034 0
W 40000020 14220002 0
W 40000024 ac030038 0
W 40000028 ac03003c 0
W 4000002c fc000000 0
W 00000000 00000001 0
P
R 80000030 00000000 0
R 80000034 00000000 0
R 80000038 00000009 0
R 8000003c 00000009 0
H 1
T halt
W 40000000 20010010 0
W 40000004 00000020 0
W 40000008 00000020 0
W 4000000c 2021ffff 0
W 40000010 00000020 0
W 40000014 00000020 0
W 40000018 1420fffc 0
W 4000001c fc000000 0
W 00000000 00000001 0
R 00000000 00000001 0
P
R 00000000 00000002 0
H 1
T apberr
W c0000000 00000001 1
R c0000000 00000000 1
R 40000000 00000000 1
W 80000000 deadbeef 1
R 00000000 00000002 0
W 00000000 00000001 0
R 80000000 00000000 1
W 4000001c 00000020 1
P
R 80000000 00000011 0
R 00000000 00000002 0
H 1
